/* mem_pipe_pkg.sv */
package mem_pipe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen = 64;               // data and byte address width

  // register index, 32 architectural registers
  typedef logic [4:0] reg_idx_t;

  localparam reg_idx_t zero_reg = 5'd0;   // hardwired zero, also the bubble dest

  ////////////////////////////////////////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////////////////////////////////////////

  // transaction tag, 0 is reserved for no transaction
  typedef logic [3:0] mem_tag_t;

  localparam mem_tag_t tag_none  = 4'd0;
  localparam mem_tag_t tag_first = 4'd1;  // first tag after reset and after wrap
  localparam mem_tag_t tag_last  = 4'd15;

  // processor to memory command
  typedef enum logic [1:0] {
    bus_none  = 2'h0,   // idle
    bus_load  = 2'h1,   // read one word, data comes back later on the tag strobe
    bus_store = 2'h2    // write one word, done in the issue cycle
  } bus_command_t;

  // tag sequence 1, 2, ... 15, 1, ... never hands out tag_none
  function automatic mem_tag_t next_tag(mem_tag_t tag);
    mem_tag_t nxt;
    if (tag == tag_last) begin
      nxt = tag_first;
    end else begin
      nxt = tag + 4'd1;
    end
    return nxt;
  endfunction

endpackage

/* mem_stage.sv */
module mem_stage import mem_pipe_pkg::*; (
  input  logic             clock,
  input  logic             reset,

  // operation from execute, held by execute while stalled
  input  logic             ex_valid,
  input  logic             ex_rd_mem,
  input  logic             ex_wr_mem,
  input  logic [xlen-1:0]  ex_alu_result,      // also the memory byte address
  input  logic [xlen-1:0]  ex_rega_value,      // store value
  input  reg_idx_t         ex_dest_reg_idx,

  // memory answers
  input  logic [xlen-1:0]  dmem2proc_data,
  input  mem_tag_t         dmem2proc_tag,      // strobe, tag of the load data present
  input  mem_tag_t         dmem2proc_response, // tag allocated this cycle

  // memory command
  output bus_command_t     proc2dmem_command,
  output logic [xlen-1:0]  proc2dmem_addr,
  output logic [xlen-1:0]  proc2dmem_data,

  // towards writeback
  output logic             mem_valid,
  output reg_idx_t         mem_dest_reg_idx,
  output logic [xlen-1:0]  mem_result,
  output logic             mem_stall
);

  mem_tag_t waiting_tag;   // tag of the load in flight, tag_none when idle
  logic     is_load;
  logic     is_store;
  logic     load_done;     // awaited load data is on the bus this cycle

  // store wins if both flags are set
  assign is_store = ex_valid & ex_wr_mem;
  assign is_load  = ex_valid & ex_rd_mem & ~ex_wr_mem;

  assign load_done = (dmem2proc_tag != tag_none) && (dmem2proc_tag == waiting_tag);

  ////////////////////////////////////////////////////////////////////////////
  // command issue
  ////////////////////////////////////////////////////////////////////////////

  // nothing new goes out while a load is outstanding
  always_comb begin
    if (waiting_tag != tag_none) begin
      proc2dmem_command = bus_none;
    end else if (is_store) begin
      proc2dmem_command = bus_store;
    end else if (is_load) begin
      proc2dmem_command = bus_load;
    end else begin
      proc2dmem_command = bus_none;
    end
  end

  assign proc2dmem_addr = ex_alu_result;   // word select is done in the memory
  assign proc2dmem_data = ex_rega_value;

  // remember the load tag at issue, drop it when the data strobe matches
  always_ff @(posedge clock) begin
    if (reset) begin
      waiting_tag <= tag_none;
    end else if (proc2dmem_command == bus_load) begin
      waiting_tag <= dmem2proc_response;
    end else if (load_done) begin
      waiting_tag <= tag_none;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stall and result
  ////////////////////////////////////////////////////////////////////////////

  // load waits for its strobe, store only if the memory gave no tag
  assign mem_stall = (is_load & ~load_done) |
                     (is_store & (dmem2proc_response == tag_none));

  assign mem_valid        = ex_valid & ~mem_stall;                // bubble while stalled
  assign mem_dest_reg_idx = mem_stall ? zero_reg : ex_dest_reg_idx;
  assign mem_result       = is_load ? dmem2proc_data : ex_alu_result;

endmodule

/* dmem_tagged.sv */
module dmem_tagged import mem_pipe_pkg::*; #(
  parameter int mem_latency   = 3,   // load issue to data strobe, 1 to 8
  parameter int mem_addr_bits = 6    // word address bits
) (
  input  logic             clock,
  input  logic             reset,

  input  bus_command_t     proc2dmem_command,
  input  logic [xlen-1:0]  proc2dmem_addr,     // byte address
  input  logic [xlen-1:0]  proc2dmem_data,

  output mem_tag_t         dmem2proc_response, // same cycle, combinational
  output mem_tag_t         dmem2proc_tag,      // load data strobe
  output logic [xlen-1:0]  dmem2proc_data
);

  localparam int mem_words = 1 << mem_addr_bits;

  logic [xlen-1:0]          mem_array [mem_words];
  logic [mem_addr_bits-1:0] word_addr;
  logic                     cmd_active;
  logic                     cmd_load;
  logic                     cmd_store;
  mem_tag_t                 tag_count;            // next tag to hand out

  // delay line, slot 0 loaded at issue, last slot drives the strobe
  mem_tag_t                 dl_tag  [mem_latency];
  logic [xlen-1:0]          dl_data [mem_latency];

  // 8 byte words, low three bits ignored
  assign word_addr = proc2dmem_addr[mem_addr_bits+2:3];

  assign cmd_active = (proc2dmem_command != bus_none);
  assign cmd_load   = (proc2dmem_command == bus_load);
  assign cmd_store  = (proc2dmem_command == bus_store);

  ////////////////////////////////////////////////////////////////////////////
  // tag allocation
  ////////////////////////////////////////////////////////////////////////////

  assign dmem2proc_response = cmd_active ? tag_count : tag_none;

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_count <= tag_first;
    end else if (cmd_active) begin
      tag_count <= next_tag(tag_count);   // wraps 15 -> 1
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word storage
  ////////////////////////////////////////////////////////////////////////////

  // one process per word, store lands at the end of the issue cycle
  for (genvar w = 0; w < mem_words; w++) begin : g_word
    always_ff @(posedge clock) begin
      if (reset) begin
        mem_array[w] <= '0;
      end else if (cmd_store && (word_addr == mem_addr_bits'(w))) begin
        mem_array[w] <= proc2dmem_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // load return delay line
  ////////////////////////////////////////////////////////////////////////////

  for (genvar s = 0; s < mem_latency; s++) begin : g_slot
    if (s == 0) begin : g_head
      // word sampled at issue, tag_none marks an empty slot
      always_ff @(posedge clock) begin
        if (reset) begin
          dl_tag[0] <= tag_none;
        end else begin
          dl_tag[0] <= cmd_load ? dmem2proc_response : tag_none;
        end
      end

      always_ff @(posedge clock) begin
        if (cmd_load) begin
          dl_data[0] <= mem_array[word_addr];   // hold old data otherwise
        end
      end
    end else begin : g_tail
      always_ff @(posedge clock) begin
        if (reset) begin
          dl_tag[s] <= tag_none;
        end else begin
          dl_tag[s] <= dl_tag[s-1];
        end
      end

      always_ff @(posedge clock) begin
        dl_data[s] <= dl_data[s-1];
      end
    end
  end

  assign dmem2proc_tag  = dl_tag[mem_latency-1];    // arrives mem_latency cycles after issue
  assign dmem2proc_data = dl_data[mem_latency-1];

endmodule

/* mem_wb_reg.sv */
module mem_wb_reg import mem_pipe_pkg::*; (
  input  logic             clock,
  input  logic             reset,

  // from the memory stage
  input  logic             mem_valid,
  input  reg_idx_t         mem_dest_reg_idx,
  input  logic [xlen-1:0]  mem_result,

  // to the register file write port
  output logic             wb_valid,
  output reg_idx_t         wb_dest_reg_idx,
  output logic [xlen-1:0]  wb_result
);

  ////////////////////////////////////////////////////////////////////////////
  // valid bit
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;        // no write right after reset
    end else begin
      wb_valid <= mem_valid;   // bubbles pass through as invalid
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////////////////////

  // only loaded on a valid op, fields sit still across bubbles
  always_ff @(posedge clock) begin
    if (mem_valid) begin
      wb_dest_reg_idx <= mem_dest_reg_idx;
      wb_result       <= mem_result;
    end
  end

endmodule

/* reg_file.sv */
module reg_file import mem_pipe_pkg::*; (
  input  logic             clock,
  input  logic             reset,

  // write port, from writeback
  input  logic             wr_en,
  input  reg_idx_t         wr_idx,
  input  logic [xlen-1:0]  wr_data,

  // read port
  input  reg_idx_t         rd_idx,
  output logic [xlen-1:0]  rd_data
);

  localparam int num_regs = 1 << $bits(reg_idx_t);

  // no storage behind register 0
  logic [xlen-1:0] regs [1:num_regs-1];

  ////////////////////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////////////////////

  // writes to index 0 match no entry and fall away
  for (genvar r = 1; r < num_regs; r++) begin : g_reg
    always_ff @(posedge clock) begin
      if (reset) begin
        regs[r] <= '0;
      end else if (wr_en && (wr_idx == reg_idx_t'(r))) begin
        regs[r] <= wr_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////////////////////

  // combinational, no write bypass
  assign rd_data = (rd_idx == zero_reg) ? '0 : regs[rd_idx];

endmodule

/* mem_pipe_top.sv */
module mem_pipe_top import mem_pipe_pkg::*; #(
  parameter int mem_latency   = 3,
  parameter int mem_addr_bits = 6
) (
  input  logic             clock,
  input  logic             reset,

  // operation from execute
  input  logic             ex_valid,
  input  logic             ex_rd_mem,
  input  logic             ex_wr_mem,
  input  logic [xlen-1:0]  ex_alu_result,
  input  logic [xlen-1:0]  ex_rega_value,
  input  reg_idx_t         ex_dest_reg_idx,

  // register file read port
  input  reg_idx_t         rd_idx,

  output logic             mem_stall,         // back-pressure to execute
  output logic             wb_valid,
  output reg_idx_t         wb_dest_reg_idx,
  output logic [xlen-1:0]  wb_result,
  output logic [xlen-1:0]  rd_data
);

  // stage to memory
  bus_command_t     proc2dmem_command;
  logic [xlen-1:0]  proc2dmem_addr;
  logic [xlen-1:0]  proc2dmem_data;

  // memory to stage
  mem_tag_t         dmem2proc_response;
  mem_tag_t         dmem2proc_tag;
  logic [xlen-1:0]  dmem2proc_data;

  // stage to mem/wb register
  logic             mem_valid;
  reg_idx_t         mem_dest_reg_idx;
  logic [xlen-1:0]  mem_result;

  mem_stage mem_stage_i (
    .clock              (clock),
    .reset              (reset),
    .ex_valid           (ex_valid),
    .ex_rd_mem          (ex_rd_mem),
    .ex_wr_mem          (ex_wr_mem),
    .ex_alu_result      (ex_alu_result),
    .ex_rega_value      (ex_rega_value),
    .ex_dest_reg_idx    (ex_dest_reg_idx),
    .dmem2proc_data     (dmem2proc_data),
    .dmem2proc_tag      (dmem2proc_tag),
    .dmem2proc_response (dmem2proc_response),
    .proc2dmem_command  (proc2dmem_command),
    .proc2dmem_addr     (proc2dmem_addr),
    .proc2dmem_data     (proc2dmem_data),
    .mem_valid          (mem_valid),
    .mem_dest_reg_idx   (mem_dest_reg_idx),
    .mem_result         (mem_result),
    .mem_stall          (mem_stall)
  );

  dmem_tagged #(
    .mem_latency   (mem_latency),
    .mem_addr_bits (mem_addr_bits)
  ) dmem_i (
    .clock              (clock),
    .reset              (reset),
    .proc2dmem_command  (proc2dmem_command),
    .proc2dmem_addr     (proc2dmem_addr),
    .proc2dmem_data     (proc2dmem_data),
    .dmem2proc_response (dmem2proc_response),
    .dmem2proc_tag      (dmem2proc_tag),
    .dmem2proc_data     (dmem2proc_data)
  );

  mem_wb_reg mem_wb_reg_i (
    .clock            (clock),
    .reset            (reset),
    .mem_valid        (mem_valid),
    .mem_dest_reg_idx (mem_dest_reg_idx),
    .mem_result       (mem_result),
    .wb_valid         (wb_valid),
    .wb_dest_reg_idx  (wb_dest_reg_idx),
    .wb_result        (wb_result)
  );

  // writeback drives the single write port
  reg_file reg_file_i (
    .clock   (clock),
    .reset   (reset),
    .wr_en   (wb_valid),
    .wr_idx  (wb_dest_reg_idx),
    .wr_data (wb_result),
    .rd_idx  (rd_idx),
    .rd_data (rd_data)
  );

endmodule

/* mem_pipe_checker.sv */
module mem_pipe_checker import mem_pipe_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  mem_tag_t      waiting_tag,
  input  bus_command_t  proc2dmem_command,
  input  logic          ex_valid,
  input  logic          ex_wr_mem,
  input  logic          mem_stall
);

  int fail_count = 0;   // assertion failures so far

  // one load in flight at most, bus stays idle the cycle after a load goes out
  assert property (@(posedge clock) disable iff (reset)
                   (proc2dmem_command == bus_load) |=> (proc2dmem_command == bus_none))
    else begin
      $error("command issued while tag %0d is outstanding", waiting_tag);
      fail_count++;
    end

  // a stalled cycle always leaves a load tag outstanding
  assert property (@(posedge clock) disable iff (reset)
                   mem_stall |=> (waiting_tag != tag_none))
    else begin
      $error("stall cycle without an outstanding load tag");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset)
                   (ex_valid && ex_wr_mem) |-> !mem_stall)   // store done at issue
    else begin
      $error("store raised the stall");
      fail_count++;
    end

endmodule

bind mem_stage mem_pipe_checker checker_i (
  .clock             (clock),
  .reset             (reset),
  .waiting_tag       (waiting_tag),
  .proc2dmem_command (proc2dmem_command),
  .ex_valid          (ex_valid),
  .ex_wr_mem         (ex_wr_mem),
  .mem_stall         (mem_stall)
);

/* mem_pipe_tb.sv */
module mem_pipe_tb import mem_pipe_pkg::*; ();

  localparam int mem_latency   = 3;
  localparam int mem_addr_bits = 6;
  localparam int mem_words     = 1 << mem_addr_bits;
  localparam int wait_limit    = 20;    // cycles before any wait gives up

  logic             clock;
  logic             reset;
  logic             ex_valid;
  logic             ex_rd_mem;
  logic             ex_wr_mem;
  logic [xlen-1:0]  ex_alu_result;
  logic [xlen-1:0]  ex_rega_value;
  reg_idx_t         ex_dest_reg_idx;
  reg_idx_t         rd_idx;
  logic             mem_stall;
  logic             wb_valid;
  reg_idx_t         wb_dest_reg_idx;
  logic [xlen-1:0]  wb_result;
  logic [xlen-1:0]  rd_data;

  logic [xlen-1:0]  model_mem  [mem_words];   // reference memory
  logic [xlen-1:0]  model_regs [32];          // reference register file
  logic [31:0]      lfsr_state;

  // expected writebacks, oldest first
  int               due_q    [$];
  reg_idx_t         dest_q   [$];
  logic [xlen-1:0]  result_q [$];

  int               cycle_count    = 0;
  int               mismatch_count = 0;
  int               other_errors   = 0;

  mem_pipe_top #(
    .mem_latency   (mem_latency),
    .mem_addr_bits (mem_addr_bits)
  ) dut_i (
    .clock (clock), .reset (reset),
    .ex_valid (ex_valid), .ex_rd_mem (ex_rd_mem), .ex_wr_mem (ex_wr_mem),
    .ex_alu_result (ex_alu_result), .ex_rega_value (ex_rega_value),
    .ex_dest_reg_idx (ex_dest_reg_idx), .rd_idx (rd_idx),
    .mem_stall (mem_stall), .wb_valid (wb_valid), .wb_dest_reg_idx (wb_dest_reg_idx),
    .wb_result (wb_result), .rd_data (rd_data)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) cycle_count++;   // read only at falling edges

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // reference, returns expected stall cycles
  function automatic int model_step(input logic rd, input logic wr,
                                    input logic [xlen-1:0] alu, input logic [xlen-1:0] val,
                                    input reg_idx_t dest, output logic [xlen-1:0] result);
    logic [mem_addr_bits-1:0] word;
    int                       stall;
    word   = alu[mem_addr_bits+2:3];   // 8 byte words
    stall  = 0;
    result = alu;                      // alu ops and stores pass the address on
    if (wr) begin
      model_mem[word] = val;
    end else if (rd) begin
      result = model_mem[word];
      stall  = mem_latency;
    end
    if (dest != zero_reg) begin
      model_regs[dest] = result;       // x0 never written
    end
    return stall;
  endfunction

  task automatic check_value(input string what, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      ex_valid  = 1'b0;
      ex_rd_mem = 1'b0;
      ex_wr_mem = 1'b0;
    end
  endtask

  // drive one op, hold it through the stall, queue the expected writeback
  task automatic issue_op(input logic rd, input logic wr, input logic [xlen-1:0] alu,
                          input logic [xlen-1:0] val, input reg_idx_t dest);
    logic [xlen-1:0] exp_result;
    int              exp_stall;
    int              stalls;
    @(negedge clock);
    ex_valid        = 1'b1;
    ex_rd_mem       = rd;
    ex_wr_mem       = wr;
    ex_alu_result   = alu;
    ex_rega_value   = val;
    ex_dest_reg_idx = dest;
    exp_stall = model_step(rd, wr, alu, val, dest, exp_result);
    stalls    = 0;
    #1;
    while (mem_stall && stalls < wait_limit) begin
      @(negedge clock);
      #1;
      stalls++;
    end
    if (mem_stall) begin
      other_errors++;
      $display("stall did not end within %0d cycles at %0t", wait_limit, $time);
    end else begin
      check_value("stall cycles", 64'(stalls), 64'(exp_stall));
      due_q.push_back(cycle_count + 1);   // accepted at the coming edge
      dest_q.push_back(dest);
      result_q.push_back(exp_result);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    go_idle(1);
    while (due_q.size() != 0 && waited < wait_limit) begin
      @(negedge clock);
      #1;
      waited++;
    end
    if (due_q.size() != 0) begin
      other_errors++;
      $display("%0d writebacks still missing at %0t", due_q.size(), $time);
    end
  endtask

  task automatic read_check(input reg_idx_t idx, input logic [xlen-1:0] exp);
    @(negedge clock);
    ex_valid = 1'b0;
    rd_idx   = idx;
    #1;
    check_value($sformatf("register x%0d", idx), rd_data, exp);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < 32; i++) begin
      read_check(reg_idx_t'(i), model_regs[reg_idx_t'(i)]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // writeback compare
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    forever begin
      @(negedge clock);   // wb outputs are registered, stable here
      if (wb_valid === 1'b1) begin
        if (due_q.size() == 0) begin
          other_errors++;
          $display("unexpected writeback to x%0d at %0t", wb_dest_reg_idx, $time);
        end else begin
          check_value("writeback cycle", 64'(cycle_count), 64'(due_q.pop_front()));
          check_value("writeback dest", 64'(wb_dest_reg_idx), 64'(dest_q.pop_front()));
          check_value("writeback result", wb_result, result_q.pop_front());
        end
      end else if (due_q.size() != 0 && due_q[0] < cycle_count) begin
        other_errors++;
        $display("writeback due in cycle %0d never came, now %0t", due_q[0], $time);
        due_q.delete(0);
        dest_q.delete(0);
        result_q.delete(0);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [xlen-1:0] addr;
    logic [xlen-1:0] r;
    int              assert_fails;
    reset = 1'b1;
    ex_valid = 1'b0;
    ex_rd_mem = 1'b0;
    ex_wr_mem = 1'b0;
    ex_alu_result = '0;
    ex_rega_value = '0;
    ex_dest_reg_idx = zero_reg;
    rd_idx = zero_reg;
    lfsr_state = 32'hea609d20;
    model_mem  = '{default: '0};
    model_regs = '{default: '0};
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_value("wb_valid after reset", 64'(wb_valid), '0);

    // store right out of reset, no stale load tag may hold it back
    issue_op(1'b0, 1'b1, rand_bits(64), rand_bits(64), zero_reg);
    wait_drain();
    check_all_regs();

    // alu only, dest x5
    issue_op(1'b0, 1'b0, rand_bits(64), '0, 5'd5);
    wait_drain();
    read_check(5'd5, model_regs[5]);

    // store then load, same word
    addr = rand_bits(64);
    issue_op(1'b0, 1'b1, addr, rand_bits(64), zero_reg);
    issue_op(1'b1, 1'b0, addr, '0, 5'd7);
    wait_drain();
    read_check(5'd7, model_regs[7]);

    // x0 as destination stays zero
    issue_op(1'b1, 1'b0, addr, '0, zero_reg);
    issue_op(1'b0, 1'b0, rand_bits(64), '0, zero_reg);
    wait_drain();
    read_check(zero_reg, '0);

    // 20 loads back to back, tag counter wraps
    for (int i = 0; i < 20; i++) begin
      issue_op(1'b0, 1'b1, 64'(i * 8), rand_bits(64), zero_reg);
    end
    for (int i = 0; i < 20; i++) begin
      issue_op(1'b1, 1'b0, 64'(i * 8), '0, reg_idx_t'(i % 31 + 1));
    end
    wait_drain();

    // random mix, occasional bubble
    for (int n = 0; n < 300; n++) begin
      r = rand_bits(2);
      if (r[1:0] == 2'd1) begin
        issue_op(1'b1, 1'b0, rand_bits(64), '0, reg_idx_t'(rand_bits(5)));
      end else if (r[1:0] == 2'd2) begin
        issue_op(1'b0, 1'b1, rand_bits(64), rand_bits(64), zero_reg);
      end else begin
        issue_op(1'b0, 1'b0, rand_bits(64), '0, reg_idx_t'(rand_bits(5)));
      end
      if (rand_bits(3) == 64'd0) begin
        go_idle(1);
      end
    end
    wait_drain();
    check_all_regs();

    assert_fails = dut_i.mem_stage_i.checker_i.fail_count;
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_errors, assert_fails);
    if (mismatch_count == 0 && other_errors == 0 && assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* mem_pipe.f */
mem_pipe_pkg.sv
mem_stage.sv
dmem_tagged.sv
mem_wb_reg.sv
reg_file.sv
mem_pipe_top.sv
mem_pipe_checker.sv
mem_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert --top-module mem_pipe_tb -f mem_pipe.f \
  -o mem_pipe_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mem_pipe_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
